//--- eth_pkg.sv
package eth_pkg;

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ipv4_t;
	typedef logic [15:0] ethertype_t;

	localparam ethertype_t ETH_TYPE_ARP  = 16'h0806;
	localparam ethertype_t ETH_TYPE_IPV4 = 16'h0800;

	// ARP over Ethernet carrying IPv4
	localparam logic [15:0] ARP_HTYPE_ETH = 16'h0001;
	localparam logic [7:0]  ARP_HLEN      = 8'd6;
	localparam logic [7:0]  ARP_PLEN      = 8'd4;
	localparam logic [15:0] ARP_OPER_REQ  = 16'd1;
	localparam logic [15:0] ARP_OPER_RPL  = 16'd2;
	localparam int          ARP_LEN       = 28;

	// Station addresses
	localparam mac_addr_t DEV_MAC  = 48'h02_00_00_00_00_01;
	localparam ipv4_t     DEV_IPV4 = {8'd192, 8'd168, 8'd1, 8'd10};

endpackage

//--- mac_pkg.sv
package mac_pkg;

	import eth_pkg::*;

	typedef struct packed {
		mac_addr_t  dst;
		mac_addr_t  src;
		ethertype_t ethertype;
	} mac_hdr_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} tx_byte_t;

	localparam int HDR_LEN       = 14;
	localparam int MIN_FRAME_LEN = 60;

	localparam int PLD_FIFO_DEPTH = 32;
	localparam int HDR_FIFO_DEPTH = 2;

	// Source 0 is ARP, source 1 is user
	localparam int N_SRC = 2;

endpackage

//--- frame_fifo.sv
module frame_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 4
) (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   push,
	input  entry_t din,
	input  logic   pop,
	output entry_t dout,
	output logic   empty,
	output logic   full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = AW + 1;

	entry_t        mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(do_push) - CW'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// Head entry is shown without a read request
	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == CW'(DEPTH));

endmodule

//--- mac_rx.sv
module mac_rx import eth_pkg::*, mac_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] rx_data,
	input  logic       rx_valid,
	input  logic       rx_last,
	output mac_addr_t  rx_dst,
	output mac_addr_t  rx_src,
	output ethertype_t rx_type,
	output logic       hdr_done,
	output logic [7:0] pld_data,
	output logic       pld_valid,
	output logic       pld_last
);

	logic [3:0] byte_cnt;
	logic       in_pld;
	mac_hdr_t   hdr;

	// Counter stops at HDR_LEN for the rest of the frame
	assign in_pld = (byte_cnt == 4'(HDR_LEN));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			byte_cnt  <= '0;
			hdr_done  <= 1'b0;
			pld_valid <= 1'b0;
			pld_last  <= 1'b0;
		end else begin
			hdr_done  <= rx_valid && (byte_cnt == 4'(HDR_LEN - 1));
			pld_valid <= rx_valid && in_pld;
			pld_last  <= rx_valid && in_pld && rx_last;
			if (rx_valid) begin
				if (rx_last)
					byte_cnt <= '0;
				else if (!in_pld)
					byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	// Header bytes arrive most significant first
	always_ff @(posedge clk) begin
		if (rx_valid && !in_pld)
			hdr <= {hdr[8*HDR_LEN-9:0], rx_data};
		pld_data <= rx_data;
	end

	assign rx_dst  = hdr.dst;
	assign rx_src  = hdr.src;
	assign rx_type = hdr.ethertype;

endmodule

//--- arp_responder.sv
module arp_responder import eth_pkg::*, mac_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  mac_addr_t  rx_src,
	input  ethertype_t rx_type,
	input  logic       hdr_done,
	input  logic [7:0] pld_data,
	input  logic       pld_valid,
	input  logic       pld_last,
	input  logic       pld_full,
	output logic       hdr_push,
	output mac_hdr_t   hdr_in,
	output logic       pld_push,
	output tx_byte_t   pld_in
);

	localparam int ARP_W = 8 * ARP_LEN;

	logic             arp_frm;
	logic [4:0]       rx_off;
	logic [ARP_W-1:0] arp_sr;
	logic [ARP_W-1:0] arp_nxt;
	logic             req_ok;
	logic             accept;
	logic             busy;
	logic [4:0]       tx_off;
	mac_addr_t        rpl_dst;
	mac_addr_t        rpl_tha;
	ipv4_t            rpl_tpa;
	logic [ARP_W-1:0] rpl;

	// Bytes after the ARP body are trailer and not stored
	assign arp_nxt = (rx_off < 5'(ARP_LEN)) ? {arp_sr[ARP_W-9:0], pld_data} : arp_sr;

	assign req_ok = (arp_nxt[ARP_W-1 -: 16] == ARP_HTYPE_ETH) &&
		(arp_nxt[ARP_W-17 -: 16] == ETH_TYPE_IPV4) &&
		(arp_nxt[ARP_W-49 -: 16] == ARP_OPER_REQ) &&
		(arp_nxt[31:0] == DEV_IPV4);

	assign accept = pld_valid && pld_last && arp_frm && !busy &&
		(rx_off >= 5'(ARP_LEN - 1)) && req_ok;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arp_frm  <= 1'b0;
			rx_off   <= '0;
			busy     <= 1'b0;
			tx_off   <= '0;
			hdr_push <= 1'b0;
		end else begin
			hdr_push <= accept;
			if (hdr_done) begin
				arp_frm <= (rx_type == ETH_TYPE_ARP);
				rx_off  <= '0;
			end else if (pld_valid && arp_frm) begin
				if (pld_last)
					arp_frm <= 1'b0;
				if (rx_off < 5'(ARP_LEN))
					rx_off <= rx_off + 1'b1;
			end
			if (accept) begin
				busy   <= 1'b1;
				tx_off <= '0;
			end else if (pld_push) begin
				if (tx_off == 5'(ARP_LEN - 1))
					busy <= 1'b0;
				tx_off <= tx_off + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pld_valid && arp_frm)
			arp_sr <= arp_nxt;
		if (accept) begin
			rpl_dst <= rx_src;
			rpl_tha <= arp_nxt[ARP_W-65 -: 48];
			rpl_tpa <= arp_nxt[ARP_W-113 -: 32];
		end
	end

	assign rpl = {ARP_HTYPE_ETH, ETH_TYPE_IPV4, ARP_HLEN, ARP_PLEN, ARP_OPER_RPL,
		DEV_MAC, DEV_IPV4, rpl_tha, rpl_tpa};

	assign hdr_in   = '{dst: rpl_dst, src: DEV_MAC, ethertype: ETH_TYPE_ARP};
	assign pld_push = busy && !pld_full;
	assign pld_in   = '{data: rpl[8*(ARP_LEN-1-int'(tx_off)) +: 8],
		last: (tx_off == 5'(ARP_LEN - 1))};

endmodule

//--- tx_buf_mng.sv
module tx_buf_mng import eth_pkg::*, mac_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       arp_hdr_push,
	input  mac_hdr_t   arp_hdr_in,
	input  logic       arp_pld_push,
	input  tx_byte_t   arp_pld_in,
	input  mac_addr_t  usr_dst,
	input  ethertype_t usr_type,
	input  logic [7:0] usr_data,
	input  logic       usr_valid,
	input  logic       usr_last,
	input  logic       tx_ack,
	input  logic       pld_pop,
	output logic       arp_pld_full,
	output logic       usr_ready,
	output logic       tx_req,
	output mac_hdr_t   tx_hdr,
	output logic [7:0] pld_byte,
	output logic       pld_last,
	output logic       pld_avail
);

	typedef enum logic [1:0] {ARB_IDLE, ARB_REQ, ARB_REL} arb_state_t;

	arb_state_t state;
	logic       sel;
	logic       rr;
	logic       usr_first;
	logic       usr_push;
	logic       hdr_pop;

	logic     hdr_push_v [N_SRC];
	mac_hdr_t hdr_in_v   [N_SRC];
	logic     hdr_pop_v  [N_SRC];
	mac_hdr_t hdr_dout   [N_SRC];
	logic     hdr_empty  [N_SRC];
	logic     hdr_full   [N_SRC];
	logic     pld_push_v [N_SRC];
	tx_byte_t pld_in_v   [N_SRC];
	logic     pld_pop_v  [N_SRC];
	tx_byte_t pld_dout   [N_SRC];
	logic     pld_empty  [N_SRC];
	logic     pld_full   [N_SRC];

	assign hdr_push_v[0] = arp_hdr_push;
	assign hdr_in_v[0]   = arp_hdr_in;
	assign pld_push_v[0] = arp_pld_push;
	assign pld_in_v[0]   = arp_pld_in;
	assign arp_pld_full  = pld_full[0];

	// User header is taken from the sideband on the first byte
	assign usr_ready     = !pld_full[1] && (!usr_first || !hdr_full[1]);
	assign usr_push      = usr_valid && usr_ready;
	assign hdr_push_v[1] = usr_push && usr_first;
	assign hdr_in_v[1]   = '{dst: usr_dst, src: DEV_MAC, ethertype: usr_type};
	assign pld_push_v[1] = usr_push;
	assign pld_in_v[1]   = '{data: usr_data, last: usr_last};

	for (genvar s = 0; s < N_SRC; s++) begin : g_src
		assign hdr_pop_v[s] = hdr_pop && (sel == 1'(s));
		assign pld_pop_v[s] = pld_pop && (sel == 1'(s));

		frame_fifo #(.entry_t(mac_hdr_t), .DEPTH(HDR_FIFO_DEPTH)) u_hdr_fifo (
			.clk, .arst_n,
			.push (hdr_push_v[s]), .din (hdr_in_v[s]), .pop (hdr_pop_v[s]),
			.dout (hdr_dout[s]), .empty (hdr_empty[s]), .full (hdr_full[s])
		);

		frame_fifo #(.entry_t(tx_byte_t), .DEPTH(PLD_FIFO_DEPTH)) u_pld_fifo (
			.clk, .arst_n,
			.push (pld_push_v[s]), .din (pld_in_v[s]), .pop (pld_pop_v[s]),
			.dout (pld_dout[s]), .empty (pld_empty[s]), .full (pld_full[s])
		);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			usr_first <= 1'b1;
			state     <= ARB_IDLE;
			sel       <= 1'b0;
			rr        <= 1'b0;
			tx_req    <= 1'b0;
		end else begin
			if (usr_push)
				usr_first <= usr_last;
			case (state)
				ARB_IDLE: if (!hdr_empty[rr] || !hdr_empty[!rr]) begin
					// Preferred source first, else the other one
					sel    <= hdr_empty[rr] ? !rr : rr;
					tx_req <= 1'b1;
					state  <= ARB_REQ;
				end
				ARB_REQ: if (tx_ack) begin
					tx_req <= 1'b0;
					rr     <= !sel;
					state  <= ARB_REL;
				end
				ARB_REL: if (!tx_ack)
					state <= ARB_IDLE;
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign hdr_pop   = (state == ARB_REQ) && tx_ack;
	assign tx_hdr    = hdr_dout[sel];
	assign pld_byte  = pld_dout[sel].data;
	assign pld_last  = pld_dout[sel].last;
	assign pld_avail = !pld_empty[sel];

endmodule

//--- mac_tx.sv
module mac_tx import mac_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       tx_req,
	input  mac_hdr_t   tx_hdr,
	input  logic [7:0] pld_byte,
	input  logic       pld_last,
	input  logic       pld_avail,
	output logic       tx_ack,
	output logic       pld_pop,
	output logic [7:0] phy_data,
	output logic       phy_valid,
	output logic       phy_last
);

	typedef enum logic [2:0] {ST_IDLE, ST_HDR, ST_PLD, ST_PAD, ST_ACK} state_t;

	state_t     state;
	logic [5:0] cnt;
	logic [7:0] hdr_byte;

	// cnt is the index of the byte being registered onto the PHY
	assign hdr_byte = tx_hdr[8*(HDR_LEN-1-int'(cnt)) +: 8];
	assign pld_pop  = (state == ST_PLD) && pld_avail;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			cnt       <= '0;
			tx_ack    <= 1'b0;
			phy_valid <= 1'b0;
			phy_last  <= 1'b0;
		end else begin
			phy_valid <= 1'b0;
			phy_last  <= 1'b0;
			case (state)
				ST_IDLE: if (tx_req) begin
					phy_valid <= 1'b1;
					cnt       <= 6'd1;
					state     <= ST_HDR;
				end
				ST_HDR: begin
					phy_valid <= 1'b1;
					cnt       <= cnt + 1'b1;
					if (cnt == 6'(HDR_LEN - 1))
						state <= ST_PLD;
				end
				ST_PLD: if (pld_avail) begin
					phy_valid <= 1'b1;
					if (cnt != 6'(MIN_FRAME_LEN))
						cnt <= cnt + 1'b1;
					if (pld_last) begin
						if (cnt >= 6'(MIN_FRAME_LEN - 1)) begin
							phy_last <= 1'b1;
							state    <= ST_ACK;
						end else begin
							state <= ST_PAD;
						end
					end
				end
				ST_PAD: begin
					phy_valid <= 1'b1;
					cnt       <= cnt + 1'b1;
					if (cnt == 6'(MIN_FRAME_LEN - 1)) begin
						phy_last <= 1'b1;
						state    <= ST_ACK;
					end
				end
				ST_ACK: if (!tx_ack) begin
					tx_ack <= 1'b1;
				end else if (!tx_req) begin
					tx_ack <= 1'b0;
					cnt    <= '0;
					state  <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE, ST_HDR: phy_data <= hdr_byte;
			ST_PLD:          phy_data <= pld_byte;
			default:         phy_data <= '0;
		endcase
	end

endmodule

//--- eth_core.sv
module eth_core import eth_pkg::*, mac_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] rx_data,
	input  logic       rx_valid,
	input  logic       rx_last,
	input  mac_addr_t  usr_dst,
	input  ethertype_t usr_type,
	input  logic [7:0] usr_data,
	input  logic       usr_valid,
	input  logic       usr_last,
	output logic       usr_ready,
	output logic [7:0] phy_data,
	output logic       phy_valid,
	output logic       phy_last
);

	mac_addr_t  rx_src;
	ethertype_t rx_type;
	logic       hdr_done;
	logic [7:0] rx_pld_data;
	logic       rx_pld_valid;
	logic       rx_pld_last;

	logic       arp_hdr_push;
	mac_hdr_t   arp_hdr_in;
	logic       arp_pld_push;
	tx_byte_t   arp_pld_in;
	logic       arp_pld_full;

	logic       tx_req;
	logic       tx_ack;
	mac_hdr_t   tx_hdr;
	logic       tx_pld_pop;
	logic [7:0] tx_pld_byte;
	logic       tx_pld_last;
	logic       tx_pld_avail;

	// Destination field is not needed by any receive consumer
	mac_rx u_mac_rx (
		.clk, .arst_n, .rx_data, .rx_valid, .rx_last,
		.rx_dst (), .rx_src, .rx_type, .hdr_done,
		.pld_data (rx_pld_data), .pld_valid (rx_pld_valid), .pld_last (rx_pld_last)
	);

	arp_responder u_arp_responder (
		.clk, .arst_n, .rx_src, .rx_type, .hdr_done,
		.pld_data (rx_pld_data), .pld_valid (rx_pld_valid), .pld_last (rx_pld_last),
		.pld_full (arp_pld_full),
		.hdr_push (arp_hdr_push), .hdr_in (arp_hdr_in),
		.pld_push (arp_pld_push), .pld_in (arp_pld_in)
	);

	tx_buf_mng u_tx_buf_mng (
		.clk, .arst_n, .arp_hdr_push, .arp_hdr_in, .arp_pld_push, .arp_pld_in,
		.usr_dst, .usr_type, .usr_data, .usr_valid, .usr_last,
		.tx_ack, .pld_pop (tx_pld_pop), .arp_pld_full, .usr_ready, .tx_req, .tx_hdr,
		.pld_byte (tx_pld_byte), .pld_last (tx_pld_last), .pld_avail (tx_pld_avail)
	);

	mac_tx u_mac_tx (
		.clk, .arst_n, .tx_req, .tx_hdr,
		.pld_byte (tx_pld_byte), .pld_last (tx_pld_last), .pld_avail (tx_pld_avail),
		.tx_ack, .pld_pop (tx_pld_pop), .phy_data, .phy_valid, .phy_last
	);

endmodule

//--- eth_core_checker.sv
module eth_core_checker import mac_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic tx_req,
	input logic tx_ack,
	input logic phy_valid,
	input logic phy_last,
	input logic usr_valid,
	input logic usr_last,
	input logic usr_ready,
	input logic usr_pld_pop,
	input logic usr_hdr_pop
);

	timeunit 1ns;
	timeprecision 1ps;

	int         fail_cnt;
	logic [6:0] frm_cnt;
	logic       usr_acc;
	logic       usr_sof;
	logic [5:0] usr_pld_cnt;
	logic [1:0] usr_hdr_cnt;

	initial fail_cnt = 0;

	assign usr_acc = usr_valid && usr_ready;

	// Bytes already sent in the current PHY frame
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frm_cnt <= '0;
		end else if (phy_valid) begin
			if (phy_last)
				frm_cnt <= '0;
			else if (frm_cnt != 7'd127)
				frm_cnt <= frm_cnt + 1'b1;
		end
	end

	// User FIFO occupancy rebuilt from push and pop traffic
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			usr_sof     <= 1'b1;
			usr_pld_cnt <= '0;
			usr_hdr_cnt <= '0;
		end else begin
			if (usr_acc)
				usr_sof <= usr_last;
			usr_pld_cnt <= usr_pld_cnt + 6'(usr_acc) - 6'(usr_pld_pop);
			usr_hdr_cnt <= usr_hdr_cnt + 2'(usr_acc && usr_sof) - 2'(usr_hdr_pop);
		end
	end

	reset_quiet: assert property (@(posedge clk) $rose(arst_n) |-> !phy_valid && !tx_req)
		else begin
			$error("phy_valid or tx_req high in the first cycle after reset");
			fail_cnt++;
		end

	req_held: assert property (@(posedge clk) disable iff (!arst_n) $fell(tx_req) |-> tx_ack)
		else begin
			$error("tx_req dropped before tx_ack");
			fail_cnt++;
		end

	ack_held: assert property (@(posedge clk) disable iff (!arst_n) $fell(tx_ack) |-> !tx_req)
		else begin
			$error("tx_ack dropped while tx_req still high");
			fail_cnt++;
		end

	min_len: assert property (@(posedge clk) disable iff (!arst_n)
		phy_valid && phy_last |-> frm_cnt >= 7'(MIN_FRAME_LEN - 1))
		else begin
			$error("PHY frame shorter than the minimum length");
			fail_cnt++;
		end

	gap: assert property (@(posedge clk) disable iff (!arst_n)
		phy_valid && phy_last |=> !phy_valid [*2])
		else begin
			$error("fewer than 2 idle cycles between PHY frames");
			fail_cnt++;
		end

	usr_room: assert property (@(posedge clk) disable iff (!arst_n)
		usr_pld_cnt < 6'(PLD_FIFO_DEPTH) &&
		(!usr_sof || usr_hdr_cnt < 2'(HDR_FIFO_DEPTH)) |-> usr_ready)
		else begin
			$error("usr_ready low although the user FIFOs have room");
			fail_cnt++;
		end

endmodule

bind eth_core eth_core_checker u_eth_core_checker (
	.clk, .arst_n, .tx_req, .tx_ack, .phy_valid, .phy_last,
	.usr_valid, .usr_last, .usr_ready,
	.usr_pld_pop (u_tx_buf_mng.pld_pop_v[1]),
	.usr_hdr_pop (u_tx_buf_mng.hdr_pop_v[1])
);

//--- tb_eth_core.sv
module tb_eth_core import eth_pkg::*, mac_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_PERIOD = 20;
	localparam logic [31:0] SEED       = 32'h66ade43f;
	localparam int          T_IDLE     = 40;
	localparam int          T_FRAME    = 400;
	localparam int          T_QUIET    = 200;
	localparam int          T_STIM     = 800;
	// Six expected frames, two quiet windows, the idle test and all stimulus
	localparam int          RUN_CYCLES = T_IDLE + 6 * T_FRAME + 2 * T_QUIET + T_STIM;

	localparam mac_addr_t  REQ_MAC  = 48'h02_11_22_33_44_55;
	localparam ipv4_t      REQ_IP   = {8'd192, 8'd168, 8'd1, 8'd20};
	localparam ipv4_t      OTHER_IP = {8'd192, 8'd168, 8'd1, 8'd99};
	localparam mac_addr_t  USR_DST  = 48'h02_aa_bb_cc_dd_ee;
	localparam ethertype_t USR_TYPE = 16'h88b5;

	logic       clk;
	logic       arst_n;
	logic [7:0] rx_data;
	logic       rx_valid;
	logic       rx_last;
	mac_addr_t  usr_dst;
	ethertype_t usr_type;
	logic [7:0] usr_data;
	logic       usr_valid;
	logic       usr_last;
	logic       usr_ready;
	logic [7:0] phy_data;
	logic       phy_valid;
	logic       phy_last;

	logic [7:0] rx_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] usr_pld[$];
	logic [7:0] cap_bytes[$];
	int         cap_lens[$];
	int         cur_len = 0;
	int         errors;
	int         err_mark;
	int         tests_run;
	int         tests_failed;
	int         chk_fails;
	int         n_arp;
	int         n_usr;
	bit         saw_not_ready;

	eth_core u_eth_core (
		.clk, .arst_n, .rx_data, .rx_valid, .rx_last,
		.usr_dst, .usr_type, .usr_data, .usr_valid, .usr_last, .usr_ready,
		.phy_data, .phy_valid, .phy_last
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// PHY outputs change on the rising edge and are settled at the falling one
	always @(negedge clk) begin
		if (arst_n && phy_valid) begin
			cap_bytes.push_back(phy_data);
			cur_len++;
			if (phy_last) begin
				cap_lens.push_back(cur_len);
				cur_len = 0;
			end
		end
	end

	initial begin
		#(CLK_PERIOD * (RUN_CYCLES + RUN_CYCLES / 4));
		$display("watchdog expired, test sequence did not complete in %0d cycles", RUN_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic rx_bytes(input logic [47:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			rx_q.push_back(v[8*i +: 8]);
	endtask

	task automatic exp_bytes(input logic [47:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			exp_q.push_back(v[8*i +: 8]);
	endtask

	task automatic pad_to_min();
		while (exp_q.size() < MIN_FRAME_LEN)
			exp_q.push_back(8'h00);
	endtask

	task automatic arp_request_frame(input ipv4_t tpa);
		rx_q.delete();
		rx_bytes(48'hffff_ffff_ffff, 6);
		rx_bytes(REQ_MAC, 6);
		rx_bytes(ETH_TYPE_ARP, 2);
		rx_bytes(16'h0001, 2);
		rx_bytes(ETH_TYPE_IPV4, 2);
		rx_bytes(8'd6, 1);
		rx_bytes(8'd4, 1);
		rx_bytes(ARP_OPER_REQ, 2);
		rx_bytes(REQ_MAC, 6);
		rx_bytes(REQ_IP, 4);
		rx_bytes(48'h0, 6);
		rx_bytes(tpa, 4);
		while (rx_q.size() < MIN_FRAME_LEN)
			rx_q.push_back(8'h00);
	endtask

	// Reply goes back to the requester with the device as sender
	task automatic arp_reply_frame();
		exp_q.delete();
		exp_bytes(REQ_MAC, 6);
		exp_bytes(DEV_MAC, 6);
		exp_bytes(ETH_TYPE_ARP, 2);
		exp_bytes(16'h0001, 2);
		exp_bytes(ETH_TYPE_IPV4, 2);
		exp_bytes(8'd6, 1);
		exp_bytes(8'd4, 1);
		exp_bytes(ARP_OPER_RPL, 2);
		exp_bytes(DEV_MAC, 6);
		exp_bytes(DEV_IPV4, 4);
		exp_bytes(REQ_MAC, 6);
		exp_bytes(REQ_IP, 4);
		pad_to_min();
	endtask

	task automatic user_frame(input int off, input int len);
		exp_q.delete();
		exp_bytes(USR_DST, 6);
		exp_bytes(DEV_MAC, 6);
		exp_bytes(USR_TYPE, 2);
		for (int i = 0; i < len; i++)
			exp_q.push_back(usr_pld[off + i]);
		pad_to_min();
	endtask

	task automatic random_payload(input int n);
		usr_pld.delete();
		repeat (n) usr_pld.push_back(8'($urandom));
	endtask

	task automatic drive_rx();
		for (int i = 0; i < rx_q.size(); i++) begin
			rx_data  <= rx_q[i];
			rx_valid <= 1'b1;
			rx_last  <= (i == rx_q.size() - 1);
			@(posedge clk);
		end
		rx_valid <= 1'b0;
		rx_last  <= 1'b0;
	endtask

	task automatic send_user(input int off, input int len);
		int idx;
		idx = 0;
		usr_dst   <= USR_DST;
		usr_type  <= USR_TYPE;
		usr_valid <= 1'b1;
		usr_data  <= usr_pld[off];
		usr_last  <= (len == 1);
		while (idx < len) begin
			@(posedge clk);
			if (usr_ready) begin
				idx++;
				if (idx < len) begin
					usr_data <= usr_pld[off + idx];
					usr_last <= (idx == len - 1);
				end
			end else begin
				saw_not_ready = 1'b1;
			end
		end
		usr_valid <= 1'b0;
		usr_last  <= 1'b0;
	endtask

	task automatic wait_frames(input int n, input int limit);
		int c;
		c = 0;
		while (cap_lens.size() < n && c < limit) begin
			@(posedge clk);
			c++;
		end
		assert (cap_lens.size() >= n) else begin
			$display("timed out after %0d cycles waiting for %0d frame(s), %0d captured",
				limit, n, cap_lens.size());
			errors++;
		end
	endtask

	task automatic check_frame();
		int         n;
		logic [7:0] b;
		assert (cap_lens.size() != 0) else begin
			$display("no PHY frame captured where one was expected at %0t", $time);
			errors++;
		end
		if (cap_lens.size() != 0) begin
			n = cap_lens.pop_front();
			assert (n == exp_q.size()) else begin
				$display("mismatch at %0t: frame length got %0d expected %0d",
					$time, n, exp_q.size());
				errors++;
			end
			for (int i = 0; i < n; i++) begin
				b = cap_bytes.pop_front();
				if (i < exp_q.size()) begin
					assert (b == exp_q[i]) else begin
						$display("mismatch at %0t: phy_data byte %0d got %02h expected %02h",
							$time, i, b, exp_q[i]);
						errors++;
					end
				end
			end
		end
	endtask

	task automatic assert_silent();
		assert (cap_bytes.size() == 0) else begin
			$display("unexpected PHY output, %0d byte(s) captured", cap_bytes.size());
			errors++;
		end
		cap_bytes.delete();
		cap_lens.delete();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
		err_mark = errors;
	endtask

	initial begin
		void'($urandom(SEED));
		errors        = 0;
		err_mark      = 0;
		tests_run     = 0;
		tests_failed  = 0;
		n_arp         = 0;
		n_usr         = 0;
		saw_not_ready = 1'b0;
		arst_n        = 1'b0;
		rx_data       = '0;
		rx_valid      = 1'b0;
		rx_last       = 1'b0;
		usr_dst       = '0;
		usr_type      = '0;
		usr_data      = '0;
		usr_valid     = 1'b0;
		usr_last      = 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		idle(T_IDLE);
		assert_silent();
		end_test("idle after reset");

		random_payload(10);
		send_user(0, 10);
		user_frame(0, 10);
		wait_frames(1, T_FRAME);
		check_frame();
		end_test("short user frame");

		idle(2 + $urandom % 4);
		arp_request_frame(DEV_IPV4);
		drive_rx();
		arp_reply_frame();
		wait_frames(1, T_FRAME);
		check_frame();
		idle(T_QUIET);
		assert_silent();
		end_test("ARP reply");

		arp_request_frame(OTHER_IP);
		drive_rx();
		idle(2 + $urandom % 4);
		rx_q.delete();
		rx_bytes(DEV_MAC, 6);
		rx_bytes(REQ_MAC, 6);
		rx_bytes(ETH_TYPE_IPV4, 2);
		repeat (46) rx_q.push_back(8'($urandom));
		drive_rx();
		idle(T_QUIET);
		assert_silent();
		end_test("frames to ignore");

		// User frame queues up while the reply is pending or on the wire
		arp_request_frame(DEV_IPV4);
		random_payload(30);
		drive_rx();
		send_user(0, 30);
		wait_frames(2, 2 * T_FRAME);
		for (int k = 0; k < 2; k++) begin
			if (cap_bytes.size() > 13 && {cap_bytes[12], cap_bytes[13]} == ETH_TYPE_ARP) begin
				arp_reply_frame();
				n_arp++;
			end else begin
				user_frame(0, 30);
				n_usr++;
			end
			check_frame();
		end
		assert (n_arp == 1 && n_usr == 1) else begin
			$display("expected one ARP reply and one user frame, got %0d and %0d", n_arp, n_usr);
			errors++;
		end
		end_test("ARP and user frames together");

		random_payload(200);
		saw_not_ready = 1'b0;
		send_user(0, 100);
		send_user(100, 100);
		wait_frames(2, 2 * T_FRAME);
		user_frame(0, 100);
		check_frame();
		user_frame(100, 100);
		check_frame();
		assert (saw_not_ready) else begin
			$display("usr_ready never went low during back to back long user frames");
			errors++;
		end
		end_test("long user frames with back-pressure");

		idle(4);
		chk_fails = u_eth_core.u_eth_core_checker.fail_cnt;
		$display("tests run %0d, tests failed %0d, failed checks %0d, failed assertions %0d",
			tests_run, tests_failed, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- vlog.f
eth_pkg.sv
mac_pkg.sv
frame_fifo.sv
mac_rx.sv
arp_responder.sv
tx_buf_mng.sv
mac_tx.sv
eth_core.sv
eth_core_checker.sv
tb_eth_core.sv

//--- Bender.yml
package:
  name: eth_core

sources:
  - files:
      - eth_pkg.sv
      - mac_pkg.sv
      - frame_fifo.sv
      - mac_rx.sv
      - arp_responder.sv
      - tx_buf_mng.sv
      - mac_tx.sv
      - eth_core.sv
  - target: test
    files:
      - eth_core_checker.sv
      - tb_eth_core.sv
